/* hw/div_params.svh */
`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// Operand and HI/LO register width
`define DIV_XLEN 32

// Iteration counter wide enough to count DIV_XLEN steps
`define DIV_CNT_W 6

// Thread ports sharing the divider
`define DIV_NUM_CLIENTS 2

`endif

/* hw/div_pkg.sv */
`include "div_params.svh"

package div_pkg;

    typedef logic [`DIV_XLEN-1:0] data_t;                      // Operand or HI/LO value
    typedef logic [$clog2(`DIV_NUM_CLIENTS)-1:0] client_id_t;   // Owning thread

    typedef struct packed {
        logic  is_signed;   // Treat operands as two's complement
        data_t dividend;
        data_t divisor;
    } div_req_t;

    typedef struct packed {
        data_t hi;          // Remainder
        data_t lo;          // Quotient
    } div_res_t;

    typedef enum logic [2:0] {
        IDLE,
        ITER,
        FIX,
        DONE,
        DIVZERO
    } div_state_e;

endpackage

/* hw/divider.sv */
`include "div_params.svh"

module divider (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_i,
    input  div_pkg::div_req_t req_i,
    input  logic              annul_i,
    output div_pkg::div_res_t result_o,
    output logic              ready_o
);
    import div_pkg::*;

    div_state_e            state;
    logic [`DIV_CNT_W-1:0] cnt;         // Completed iterations

    data_t                 quo;         // Dividend shifts out, quotient shifts in
    data_t                 rem;         // Partial remainder
    data_t                 dsr;         // Divisor magnitude
    logic                  neg_quo;
    logic                  neg_rem;

    data_t                 dvd_mag;
    data_t                 dsr_mag;
    logic                  dvd_neg;
    logic                  dsr_neg;
    logic [`DIV_XLEN:0]    trial;       // Remainder with next dividend bit
    logic [`DIV_XLEN:0]    diff;

    // Operand magnitudes taken at start
    always_comb begin
        dvd_neg = req_i.is_signed && req_i.dividend[`DIV_XLEN-1];
        dsr_neg = req_i.is_signed && req_i.divisor[`DIV_XLEN-1];
        dvd_mag = dvd_neg ? -req_i.dividend : req_i.dividend;
        dsr_mag = dsr_neg ? -req_i.divisor : req_i.divisor;
    end

    // One restoring step
    always_comb begin
        trial = {rem, quo[`DIV_XLEN-1]};
        diff  = trial - {1'b0, dsr};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_i) begin
                        cnt   <= '0;
                        state <= (req_i.divisor == '0) ? DIVZERO : ITER;
                    end
                end
                ITER: begin
                    if (annul_i) begin
                        state <= IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                        if (cnt == `DIV_CNT_W'(`DIV_XLEN - 1)) begin
                            state <= FIX;   // Last bit done
                        end
                    end
                end
                FIX: begin
                    state <= annul_i ? IDLE : DONE;
                end
                DIVZERO: begin
                    state <= annul_i ? IDLE : DONE;
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (start_i) begin
                    quo     <= dvd_mag;
                    rem     <= '0;
                    dsr     <= dsr_mag;
                    neg_quo <= dvd_neg ^ dsr_neg;
                    neg_rem <= dvd_neg;     // Remainder follows the dividend
                end
            end
            ITER: begin
                if (!diff[`DIV_XLEN]) begin
                    rem <= diff[`DIV_XLEN-1:0];
                    quo <= {quo[`DIV_XLEN-2:0], 1'b1};
                end else begin
                    rem <= trial[`DIV_XLEN-1:0];    // Restore
                    quo <= {quo[`DIV_XLEN-2:0], 1'b0};
                end
            end
            FIX: begin
                if (neg_quo) begin
                    quo <= -quo;
                end
                if (neg_rem) begin
                    rem <= -rem;
                end
            end
            DIVZERO: begin
                quo <= '0;
                rem <= '0;
            end
            default: begin
            end
        endcase
    end

    assign result_o.hi = rem;
    assign result_o.lo = quo;
    assign ready_o     = (state == DONE);

endmodule

/* hw/div_arbiter.sv */
`include "div_params.svh"

module div_arbiter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`DIV_NUM_CLIENTS-1:0] start_i,
    input  div_pkg::div_req_t           req_i [`DIV_NUM_CLIENTS],
    input  logic [`DIV_NUM_CLIENTS-1:0] annul_i,
    output logic [`DIV_NUM_CLIENTS-1:0] busy_o,
    output logic [`DIV_NUM_CLIENTS-1:0] done_o,
    output logic                        div_start_o,
    output div_pkg::div_req_t           div_req_o,
    output logic                        div_annul_o,
    input  logic                        div_ready_i,
    output logic [`DIV_NUM_CLIENTS-1:0] wr_en_o
);
    import div_pkg::*;

    logic [`DIV_NUM_CLIENTS-1:0] pend;      // Waiting for the divider
    div_req_t                    req_q [`DIV_NUM_CLIENTS];
    client_id_t                  owner;     // Client of the running division
    logic                        in_flight;
    client_id_t                  last;      // Last client granted

    logic [`DIV_NUM_CLIENTS-1:0] live;
    client_id_t                  grant;
    client_id_t                  idx;
    logic                        found;

    // Round-robin search starting after the last served client
    always_comb begin
        live  = pend & ~annul_i;    // Annul drops a pending slot at once
        grant = last;
        found = 1'b0;
        idx   = last;
        for (int i = 1; i <= `DIV_NUM_CLIENTS; i++) begin
            idx = client_id_t'((int'(last) + i) % `DIV_NUM_CLIENTS);
            if (!found && live[idx]) begin
                grant = idx;
                found = 1'b1;
            end
        end
    end

    assign div_start_o = !in_flight && found;
    assign div_req_o   = req_q[grant];
    assign div_annul_o = in_flight && annul_i[owner];

    always_comb begin
        for (int c = 0; c < `DIV_NUM_CLIENTS; c++) begin
            busy_o[c]  = pend[c] || (in_flight && owner == client_id_t'(c));
            wr_en_o[c] = div_ready_i && in_flight && owner == client_id_t'(c) && !annul_i[c];
        end
    end

    assign done_o = wr_en_o;    // Same cycle as the HI/LO write

    always_ff @(posedge clk) begin
        if (rst) begin
            pend      <= '0;
            owner     <= '0;
            in_flight <= 1'b0;
            last      <= '0;
        end else begin
            for (int c = 0; c < `DIV_NUM_CLIENTS; c++) begin
                if (start_i[c] && !busy_o[c]) begin
                    pend[c] <= 1'b1;
                end else if (annul_i[c]) begin
                    pend[c] <= 1'b0;
                end
            end
            if (div_start_o) begin
                pend[grant] <= 1'b0;
                owner       <= grant;
                last        <= grant;
                in_flight   <= 1'b1;
            end else if (div_ready_i || div_annul_o) begin
                in_flight   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < `DIV_NUM_CLIENTS; c++) begin
            if (start_i[c] && !busy_o[c]) begin
                req_q[c] <= req_i[c];
            end
        end
    end

endmodule

/* hw/hilo_regs.sv */
`include "div_params.svh"

module hilo_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`DIV_NUM_CLIENTS-1:0] wr_en_i,
    input  div_pkg::div_res_t           res_i,
    output div_pkg::data_t              hi_o [`DIV_NUM_CLIENTS],
    output div_pkg::data_t              lo_o [`DIV_NUM_CLIENTS]
);

    // One HI/LO pair per thread
    for (genvar c = 0; c < `DIV_NUM_CLIENTS; c++) begin : g_pair
        always_ff @(posedge clk) begin
            if (rst) begin
                hi_o[c] <= '0;
                lo_o[c] <= '0;
            end else if (wr_en_i[c]) begin
                hi_o[c] <= res_i.hi;    // Remainder
                lo_o[c] <= res_i.lo;    // Quotient
            end
        end
    end

endmodule

/* hw/div_subsys_top.sv */
`include "div_params.svh"

module div_subsys_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`DIV_NUM_CLIENTS-1:0] start_i,
    input  div_pkg::div_req_t           req_i [`DIV_NUM_CLIENTS],
    input  logic [`DIV_NUM_CLIENTS-1:0] annul_i,
    output logic [`DIV_NUM_CLIENTS-1:0] busy_o,
    output logic [`DIV_NUM_CLIENTS-1:0] done_o,
    output div_pkg::data_t              hi_o [`DIV_NUM_CLIENTS],
    output div_pkg::data_t              lo_o [`DIV_NUM_CLIENTS]
);
    import div_pkg::*;

    logic                        div_start;
    div_req_t                    div_req;
    logic                        div_annul;
    logic                        div_ready;
    div_res_t                    div_res;
    logic [`DIV_NUM_CLIENTS-1:0] wr_en;     // HI/LO write per thread

    div_arbiter u_arb (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start_i),
        .req_i       (req_i),
        .annul_i     (annul_i),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .div_start_o (div_start),
        .div_req_o   (div_req),
        .div_annul_o (div_annul),
        .div_ready_i (div_ready),
        .wr_en_o     (wr_en)
    );

    divider u_div (
        .clk      (clk),
        .rst      (rst),
        .start_i  (div_start),
        .req_i    (div_req),
        .annul_i  (div_annul),
        .result_o (div_res),
        .ready_o  (div_ready)
    );

    hilo_regs u_hilo (
        .clk     (clk),
        .rst     (rst),
        .wr_en_i (wr_en),
        .res_i   (div_res),
        .hi_o    (hi_o),
        .lo_o    (lo_o)
    );

endmodule

/* sim/div_checker.sv */
`include "div_params.svh"

module div_checker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`DIV_NUM_CLIENTS-1:0] start_i,
    input  div_pkg::div_req_t           req_i [`DIV_NUM_CLIENTS],
    input  logic [`DIV_NUM_CLIENTS-1:0] annul_i,
    input  logic [`DIV_NUM_CLIENTS-1:0] busy_i,
    input  logic [`DIV_NUM_CLIENTS-1:0] done_i,
    input  div_pkg::data_t              hi_i [`DIV_NUM_CLIENTS],
    input  div_pkg::data_t              lo_i [`DIV_NUM_CLIENTS],
    input  logic                        order_chk_i,
    output int                          err_cnt_o,
    output int                          check_cnt_o,
    output int                          test_cnt_o,
    output int                          test_fail_cnt_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import div_pkg::*;

    logic [`DIV_NUM_CLIENTS-1:0] exp_busy;      // Request accepted and not yet done or annulled
    logic [`DIV_NUM_CLIENTS-1:0] was_busy;
    logic [`DIV_NUM_CLIENTS-1:0] check_next;    // HI/LO readable this cycle
    logic [`DIV_NUM_CLIENTS-1:0] busy_bad;
    div_res_t                    exp_res [`DIV_NUM_CLIENTS];
    data_t                       model_hi [`DIV_NUM_CLIENTS];
    data_t                       model_lo [`DIV_NUM_CLIENTS];
    logic                        have_last;
    int                          last_done;
    int                          err_cnt = 0;
    int                          check_cnt = 0;
    int                          test_cnt = 0;
    int                          test_fail_cnt = 0;
    int                          test_errs = 0;
    int                          test_checks = 0;

    assign err_cnt_o       = err_cnt;
    assign check_cnt_o     = check_cnt;
    assign test_cnt_o      = test_cnt;
    assign test_fail_cnt_o = test_fail_cnt;

    // Quotient sign is the XOR of operand signs and the remainder follows the dividend
    function automatic div_res_t model_div(input div_req_t r);
        logic               neg_a;
        logic               neg_b;
        logic [`DIV_XLEN:0] mag_a;
        logic [`DIV_XLEN:0] mag_b;
        logic [`DIV_XLEN:0] q;
        logic [`DIV_XLEN:0] m;
        div_res_t           res;
        neg_a = r.is_signed && r.dividend[`DIV_XLEN-1];
        neg_b = r.is_signed && r.divisor[`DIV_XLEN-1];
        mag_a = neg_a ? -{1'b1, r.dividend} : {1'b0, r.dividend};
        mag_b = neg_b ? -{1'b1, r.divisor} : {1'b0, r.divisor};
        if (r.divisor == '0) begin
            res = '0;
        end else begin
            q      = mag_a / mag_b;
            m      = mag_a % mag_b;
            res.lo = (neg_a ^ neg_b) ? -q[`DIV_XLEN-1:0] : q[`DIV_XLEN-1:0];
            res.hi = neg_a ? -m[`DIV_XLEN-1:0] : m[`DIV_XLEN-1:0];
        end
        return res;
    endfunction

    task log_mismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        err_cnt++;
        test_errs++;
    endtask

    task log_problem(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        err_cnt++;
        test_errs++;
    endtask

    task compare_hilo(input int c);
        check_cnt++;
        test_checks++;
        if (hi_i[c] !== model_hi[c] || lo_i[c] !== model_lo[c]) begin
            log_mismatch($sformatf("client %0d HI/LO %h/%h, expected %h/%h", c,
                                   hi_i[c], lo_i[c], model_hi[c], model_lo[c]));
        end
    endtask

    task end_test(input int num, input string name);
        for (int c = 0; c < `DIV_NUM_CLIENTS; c++) begin
            if (exp_busy[c]) begin
                log_problem($sformatf("client %0d still waits for done", c));
            end
            compare_hilo(c);    // Annulled threads keep old values
        end
        test_cnt++;
        if (test_errs != 0) begin
            test_fail_cnt++;
        end
        $display("Test %0d %s: %0d checks, %0d errors", num, name, test_checks, test_errs);
        test_errs   = 0;
        test_checks = 0;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            exp_busy   = '0;
            check_next = '0;
            busy_bad   = '0;
            have_last  = 1'b0;
            for (int c = 0; c < `DIV_NUM_CLIENTS; c++) begin
                model_hi[c] = '0;
                model_lo[c] = '0;
            end
        end else begin
            was_busy = exp_busy;
            if (!order_chk_i) begin
                have_last = 1'b0;
            end
            for (int c = 0; c < `DIV_NUM_CLIENTS; c++) begin
                if (check_next[c]) begin
                    compare_hilo(c);
                    check_next[c] = 1'b0;
                end
                if (busy_i[c] !== was_busy[c]) begin
                    if (!busy_bad[c]) begin
                        log_problem($sformatf("client %0d busy is %b but should be %b",
                                              c, busy_i[c], was_busy[c]));
                    end
                    busy_bad[c] = 1'b1;
                end else begin
                    busy_bad[c] = 1'b0;
                end
                if (done_i[c]) begin
                    if (!was_busy[c] || annul_i[c]) begin
                        log_problem($sformatf("client %0d done without a live request", c));
                    end else begin
                        model_hi[c]   = exp_res[c].hi;
                        model_lo[c]   = exp_res[c].lo;
                        check_next[c] = 1'b1;
                        exp_busy[c]   = 1'b0;
                        if (have_last && last_done == c) begin
                            log_problem($sformatf("client %0d finished twice in a row", c));
                        end
                        have_last = order_chk_i;
                        last_done = c;
                    end
                end
                if (annul_i[c] && was_busy[c]) begin
                    exp_busy[c] = 1'b0;     // Request dropped so busy falls next cycle
                end
                if (start_i[c] && !was_busy[c]) begin
                    exp_res[c]  = model_div(req_i[c]);
                    exp_busy[c] = 1'b1;
                end
            end
        end
    end

endmodule

/* sim/tb_div_subsys.sv */
`include "div_params.svh"

module tb_div_subsys;
    timeunit 1ns;
    timeprecision 100ps;
    import div_pkg::*;

    localparam int N_UNS       = 12;
    localparam int N_SGN       = 16;
    localparam int N_MIN       = 4;    // Most negative dividend
    localparam int N_ZERO      = 4;
    localparam int N_PAIR      = 6;    // Rounds of two ops
    localparam int N_ANNUL     = 4;    // Rounds of two ops
    localparam int N_OPS       = N_UNS + N_SGN + N_MIN + N_ZERO + 2 * N_PAIR + 2 * N_ANNUL;
    localparam int CYCLE_LIMIT = N_OPS * 2 * 40 + 500;
    localparam int WAIT_LIMIT  = 2 * 40 + 20;

    logic                        clk = 1'b0;
    logic                        rst;
    logic [`DIV_NUM_CLIENTS-1:0] start_i;
    div_req_t                    req_i [`DIV_NUM_CLIENTS];
    logic [`DIV_NUM_CLIENTS-1:0] annul_i;
    logic [`DIV_NUM_CLIENTS-1:0] busy_o;
    logic [`DIV_NUM_CLIENTS-1:0] done_o;
    data_t                       hi_o [`DIV_NUM_CLIENTS];
    data_t                       lo_o [`DIV_NUM_CLIENTS];
    logic                        order_chk;
    logic [31:0]                 rng_state;
    int                          cycles = 0;
    int                          err_cnt;
    int                          check_cnt;
    int                          test_cnt;
    int                          test_fail_cnt;

    always #4 clk = ~clk;

    div_subsys_top dut0 (
        .clk     (clk),
        .rst     (rst),
        .start_i (start_i),
        .req_i   (req_i),
        .annul_i (annul_i),
        .busy_o  (busy_o),
        .done_o  (done_o),
        .hi_o    (hi_o),
        .lo_o    (lo_o)
    );

    div_checker chk0 (
        .clk             (clk),
        .rst             (rst),
        .start_i         (start_i),
        .req_i           (req_i),
        .annul_i         (annul_i),
        .busy_i          (busy_o),
        .done_i          (done_o),
        .hi_i            (hi_o),
        .lo_i            (lo_o),
        .order_chk_i     (order_chk),
        .err_cnt_o       (err_cnt),
        .check_cnt_o     (check_cnt),
        .test_cnt_o      (test_cnt),
        .test_fail_cnt_o (test_fail_cnt)
    );

    function logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Random shift spreads quotient sizes
    function data_t rand_divisor();
        data_t d;
        d = next_rand() >> (next_rand() % 32);
        if (d == '0) begin
            d = 1;
        end
        return d;
    endfunction

    function div_req_t make_req(input logic sgn, input data_t a, input data_t b);
        div_req_t r;
        r.is_signed = sgn;
        r.dividend  = a;
        r.divisor   = b;
        return r;
    endfunction

    task drive_start(input logic [1:0] mask, input div_req_t r0, input div_req_t r1);
        start_i  <= mask;
        req_i[0] <= r0;
        req_i[1] <= r1;
        @(posedge clk);
        start_i  <= '0;
    endtask

    task drive_annul(input logic [1:0] mask);
        annul_i <= mask;
        @(posedge clk);
        annul_i <= '0;
    endtask

    task wait_done(input logic [1:0] mask);
        logic [1:0] seen;
        int         n;
        seen = '0;
        n    = 0;
        while ((seen & mask) != mask && n < WAIT_LIMIT) begin
            @(posedge clk);
            seen = seen | done_o;
            n++;
        end
        if ((seen & mask) != mask) begin
            chk0.log_problem($sformatf("done never came for clients %b", mask & ~seen));
        end
    endtask

    task wait_idle(input logic [1:0] mask);
        int n;
        @(posedge clk);
        n = 1;
        while ((busy_o & mask) != '0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if ((busy_o & mask) != '0) begin
            chk0.log_problem($sformatf("busy stuck high on clients %b", busy_o & mask));
        end
    endtask

    task finish_test(input int num, input string name);
        repeat (2) @(posedge clk);
        chk0.end_test(num, name);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        div_req_t r0;
        div_req_t r1;
        data_t    a;
        data_t    b;
        int       cl;
        int       other;
        int       dly;
        rst       = 1'b1;
        start_i   = '0;
        annul_i   = '0;
        req_i[0]  = '0;
        req_i[1]  = '0;
        order_chk = 1'b0;
        rng_state = 32'd78488;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        for (int i = 0; i < N_UNS; i++) begin
            cl = i % 2;
            r0 = make_req(1'b0, next_rand(), rand_divisor());
            drive_start(2'b01 << cl, r0, r0);
            wait_done(2'b01 << cl);
        end
        finish_test(1, "unsigned divide");

        for (int i = 0; i < N_SGN + N_MIN; i++) begin
            cl = (i / 4) % 2;
            if (i < N_SGN) begin
                a = next_rand() >> 1;
                b = rand_divisor() >> 1;
                if (b == '0) begin
                    b = 1;
                end
                if (i[0]) begin
                    a = -a;
                end
                if (i[1]) begin
                    b = -b;
                end
            end else begin
                a = 32'h8000_0000;  // No positive counterpart
                if (i == N_SGN) begin
                    b = '1;
                end else begin
                    b = (next_rand() % 100) + 1;
                end
                if (i[0]) begin
                    b = -b;
                end
            end
            r0 = make_req(1'b1, a, b);
            drive_start(2'b01 << cl, r0, r0);
            wait_done(2'b01 << cl);
        end
        finish_test(2, "signed divide");

        for (int i = 0; i < N_ZERO; i++) begin
            cl = i % 2;
            r0 = make_req(i[1], next_rand(), '0);
            drive_start(2'b01 << cl, r0, r0);
            wait_done(2'b01 << cl);
        end
        finish_test(3, "divide by zero");

        order_chk <= 1'b1;
        for (int i = 0; i < N_PAIR; i++) begin
            r0 = make_req((next_rand() % 2) != 0, next_rand(), rand_divisor());
            r1 = make_req((next_rand() % 2) != 0, next_rand(), rand_divisor());
            drive_start(2'b11, r0, r1);
            wait_done(2'b11);
        end
        finish_test(4, "simultaneous start");
        order_chk <= 1'b0;

        for (int i = 0; i < N_ANNUL; i++) begin
            cl    = i % 2;              // Annulled client
            other = 1 - cl;
            dly   = 2 + next_rand() % 19;
            r0    = make_req(1'b1, next_rand(), rand_divisor());
            if (i < N_ANNUL / 2) begin
                drive_start(2'b01 << other, r0, r0);
                drive_start(2'b01 << cl, r0, r0);
                repeat (dly) @(posedge clk);
            end else begin
                drive_start(2'b01 << cl, r0, r0);
                repeat (dly) @(posedge clk);
                drive_start(2'b01 << other, r0, r0);
                repeat (3) @(posedge clk);
            end
            drive_annul(2'b01 << cl);
            wait_idle(2'b01 << cl);
            wait_done(2'b01 << other);
        end
        finish_test(5, "annul");

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_cnt, test_fail_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+hw
hw/div_pkg.sv
hw/divider.sv
hw/div_arbiter.sv
hw/hilo_regs.sv
hw/div_subsys_top.sv
sim/div_checker.sv
sim/tb_div_subsys.sv

/* Bender.yml */
package:
  name: div_subsys

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/div_pkg.sv
      - hw/divider.sv
      - hw/div_arbiter.sv
      - hw/hilo_regs.sv
      - hw/div_subsys_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/div_checker.sv
      - sim/tb_div_subsys.sv
